/* common/lane_pkg.sv */
package lane_pkg;

  ////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////

  // Vector registers held in the lane
  localparam int unsigned NrVRegs = 8;

  // Elements per vector register
  localparam int unsigned VecElems = 4;

  // Datapath width of one element
  localparam int unsigned ElemWidth = 16;

  // Index widths derived from the geometry
  localparam int unsigned VRegIdxWidth = $clog2(NrVRegs);
  localparam int unsigned ElemIdxWidth = $clog2(VecElems);

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  // One element of a vector register
  typedef logic [ElemWidth-1:0] elem_t;

  // Register and element indices
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;
  typedef logic [ElemIdxWidth-1:0] elem_idx_t;

  // Element-wise opcodes
  // OP_VMUL runs on the multiplier, all others on the ALU
  typedef enum logic [2:0] {
    OP_VADD = 3'd0,
    OP_VSUB = 3'd1,
    OP_VAND = 3'd2,
    OP_VXOR = 3'd3,
    OP_VMUL = 3'd4
  } lane_op_e;

  // Index of the last element in a register
  localparam elem_idx_t LastElem = elem_idx_t'(VecElems - 1);

endpackage : lane_pkg

/* vfu/lane_alu.sv */
`timescale 1ns/10ps

module lane_alu import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      issue_i,
  input  lane_op_e  op_i,
  input  vreg_idx_t vd_i,
  input  elem_idx_t elem_i,
  input  elem_t     opa_i,
  input  elem_t     opb_i,
  output logic      res_valid_o,
  output vreg_idx_t res_vd_o,
  output elem_idx_t res_elem_o,
  output elem_t     res_data_o
);

  elem_t     res_d, res_q;
  logic      valid_q;
  vreg_idx_t vd_q;
  elem_idx_t elem_q;

  // Arithmetic wraps at the element width
  always_comb begin
    case (op_i)
      OP_VADD: res_d = opa_i + opb_i;
      OP_VSUB: res_d = opa_i - opb_i;
      OP_VAND: res_d = opa_i & opb_i;
      OP_VXOR: res_d = opa_i ^ opb_i;
      default: res_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      vd_q    <= '0;
      elem_q  <= '0;
      res_q   <= '0;
    end else begin
      valid_q <= issue_i;
      if (issue_i) begin
        vd_q   <= vd_i;
        elem_q <= elem_i;
        res_q  <= res_d;
      end
    end
  end

  assign res_valid_o = valid_q;
  assign res_vd_o    = vd_q;
  assign res_elem_o  = elem_q;
  assign res_data_o  = res_q;

endmodule : lane_alu

/* vfu/lane_multiplier.sv */
`timescale 1ns/10ps

module lane_multiplier import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      issue_i,
  input  vreg_idx_t vd_i,
  input  elem_idx_t elem_i,
  input  elem_t     opa_i,
  input  elem_t     opb_i,
  output logic      res_valid_o,
  output vreg_idx_t res_vd_o,
  output elem_idx_t res_elem_o,
  output elem_t     res_data_o
);

  ////////////////////////////////////////////////////////////
  // Stage 1: partial products on the two bytes of opb
  ////////////////////////////////////////////////////////////

  logic      s1_valid_q;
  vreg_idx_t s1_vd_q;
  elem_idx_t s1_elem_q;
  elem_t     pp_lo_q;
  // Upper product only reaches the top byte of the low half
  logic [7:0] pp_hi_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s1_vd_q    <= '0;
      s1_elem_q  <= '0;
      pp_lo_q    <= '0;
      pp_hi_q    <= '0;
    end else begin
      s1_valid_q <= issue_i;
      if (issue_i) begin
        s1_vd_q   <= vd_i;
        s1_elem_q <= elem_i;
        pp_lo_q   <= opa_i * opb_i[7:0];
        pp_hi_q   <= opa_i[7:0] * opb_i[15:8];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stage 2: sum, low half of the product
  ////////////////////////////////////////////////////////////

  logic      s2_valid_q;
  vreg_idx_t s2_vd_q;
  elem_idx_t s2_elem_q;
  elem_t     s2_res_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s2_valid_q <= 1'b0;
      s2_vd_q    <= '0;
      s2_elem_q  <= '0;
      s2_res_q   <= '0;
    end else begin
      s2_valid_q <= s1_valid_q;
      if (s1_valid_q) begin
        s2_vd_q   <= s1_vd_q;
        s2_elem_q <= s1_elem_q;
        s2_res_q  <= pp_lo_q + {pp_hi_q, 8'h00};
      end
    end
  end

  assign res_valid_o = s2_valid_q;
  assign res_vd_o    = s2_vd_q;
  assign res_elem_o  = s2_elem_q;
  assign res_data_o  = s2_res_q;

endmodule : lane_multiplier

/* vrf/vector_regfile.sv */
`timescale 1ns/10ps

module vector_regfile import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Operand read ports
  input  vreg_idx_t opa_vreg_i,
  input  vreg_idx_t opb_vreg_i,
  input  elem_idx_t op_elem_i,
  output elem_t     opa_o,
  output elem_t     opb_o,
  // Writeback write
  input  logic      wb_valid_i,
  input  vreg_idx_t wb_vreg_i,
  input  elem_idx_t wb_elem_i,
  input  elem_t     wb_data_i,
  // External load write
  input  logic      wr_valid_i,
  input  vreg_idx_t wr_vreg_i,
  input  elem_idx_t wr_elem_i,
  input  elem_t     wr_data_i,
  // External store read
  input  logic      rd_req_i,
  input  vreg_idx_t rd_vreg_i,
  input  elem_idx_t rd_elem_i,
  output elem_t     rd_data_o,
  output logic      rd_valid_o
);

  elem_t mem_q [NrVRegs][VecElems];

  elem_t opa_q, opb_q, rd_data_q;
  logic  rd_valid_q;

  // Shared write port, writeback has priority
  logic      we;
  vreg_idx_t waddr_vreg;
  elem_idx_t waddr_elem;
  elem_t     wdata;

  assign we         = wb_valid_i | wr_valid_i;
  assign waddr_vreg = wb_valid_i ? wb_vreg_i : wr_vreg_i;
  assign waddr_elem = wb_valid_i ? wb_elem_i : wr_elem_i;
  assign wdata      = wb_valid_i ? wb_data_i : wr_data_i;

  ////////////////////////////////////////////////////////////
  // Storage and registered reads
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q      <= '{default: '0};
      opa_q      <= '0;
      opb_q      <= '0;
      rd_data_q  <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      if (we) begin
        mem_q[waddr_vreg][waddr_elem] <= wdata;
      end
      // Reads return the value before a same-cycle write
      opa_q      <= mem_q[opa_vreg_i][op_elem_i];
      opb_q      <= mem_q[opb_vreg_i][op_elem_i];
      rd_valid_q <= rd_req_i;
      if (rd_req_i) begin
        rd_data_q <= mem_q[rd_vreg_i][rd_elem_i];
      end
    end
  end

  assign opa_o      = opa_q;
  assign opb_o      = opb_q;
  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule : vector_regfile

/* vrf/result_writeback.sv */
`timescale 1ns/10ps

module result_writeback import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // ALU result stream
  input  logic      alu_res_valid_i,
  input  vreg_idx_t alu_res_vd_i,
  input  elem_idx_t alu_res_elem_i,
  input  elem_t     alu_res_data_i,
  // Multiplier result stream
  input  logic      mul_res_valid_i,
  input  vreg_idx_t mul_res_vd_i,
  input  elem_idx_t mul_res_elem_i,
  input  elem_t     mul_res_data_i,
  // Register-file write
  output logic      wb_valid_o,
  output vreg_idx_t wb_vreg_o,
  output elem_idx_t wb_elem_o,
  output elem_t     wb_data_o,
  output logic      done_o
);

  elem_idx_t wb_cnt_q;
  logic      done_q;

  // Only one stream is active at a time
  assign wb_valid_o = alu_res_valid_i | mul_res_valid_i;
  assign wb_vreg_o  = alu_res_valid_i ? alu_res_vd_i   : mul_res_vd_i;
  assign wb_elem_o  = alu_res_valid_i ? alu_res_elem_i : mul_res_elem_i;
  assign wb_data_o  = alu_res_valid_i ? alu_res_data_i : mul_res_data_i;

  // Count element writes, pulse done after the last one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_cnt_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= wb_valid_o && (wb_cnt_q == LastElem);
      if (wb_valid_o) begin
        wb_cnt_q <= wb_cnt_q + 1'b1;
      end
    end
  end

  assign done_o = done_q;

endmodule : result_writeback

/* source/lane_sequencer.sv */
`timescale 1ns/10ps

module lane_sequencer import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction strobe
  input  logic      insn_valid_i,
  input  lane_op_e  insn_op_i,
  input  vreg_idx_t insn_vd_i,
  input  vreg_idx_t insn_vs1_i,
  input  vreg_idx_t insn_vs2_i,
  // End of instruction from writeback
  input  logic      done_i,
  output logic      busy_o,
  // Operand read addresses
  output vreg_idx_t opa_vreg_o,
  output vreg_idx_t opb_vreg_o,
  output elem_idx_t op_elem_o,
  // Unit issue, aligned with the registered operands
  output logic      alu_issue_o,
  output logic      mul_issue_o,
  output lane_op_e  issue_op_o,
  output vreg_idx_t issue_vd_o,
  output elem_idx_t issue_elem_o
);

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_e;

  seq_state_e state_q;

  // Latched instruction
  lane_op_e  op_q;
  vreg_idx_t vd_q, vs1_q, vs2_q;
  elem_idx_t elem_q;

  // Issue stage, one cycle behind the read
  logic      alu_issue_q, mul_issue_q;
  elem_idx_t issue_elem_q;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      op_q    <= OP_VADD;
      vd_q    <= '0;
      vs1_q   <= '0;
      vs2_q   <= '0;
      elem_q  <= '0;
    end else begin
      case (state_q)
        SEQ_IDLE: begin
          if (insn_valid_i) begin
            op_q    <= insn_op_i;
            vd_q    <= insn_vd_i;
            vs1_q   <= insn_vs1_i;
            vs2_q   <= insn_vs2_i;
            elem_q  <= '0;
            state_q <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          // One element read per cycle
          elem_q <= elem_q + 1'b1;
          if (elem_q == LastElem) begin
            state_q <= SEQ_WAIT;
          end
        end
        SEQ_WAIT: begin
          if (done_i) begin
            state_q <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Delay the strobe by the register-file read latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_issue_q  <= 1'b0;
      mul_issue_q  <= 1'b0;
      issue_elem_q <= '0;
    end else begin
      alu_issue_q  <= (state_q == SEQ_ISSUE) && (op_q != OP_VMUL);
      mul_issue_q  <= (state_q == SEQ_ISSUE) && (op_q == OP_VMUL);
      issue_elem_q <= elem_q;
    end
  end

  assign busy_o       = (state_q != SEQ_IDLE);
  assign opa_vreg_o   = vs1_q;
  assign opb_vreg_o   = vs2_q;
  assign op_elem_o    = elem_q;
  assign alu_issue_o  = alu_issue_q;
  assign mul_issue_o  = mul_issue_q;
  // Opcode and destination stay latched until the next instruction
  assign issue_op_o   = op_q;
  assign issue_vd_o   = vd_q;
  assign issue_elem_o = issue_elem_q;

endmodule : lane_sequencer

/* source/lane_top.sv */
`timescale 1ns/10ps

module lane_top import lane_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Instruction dispatch
  input  logic      insn_valid_i,
  input  lane_op_e  insn_op_i,
  input  vreg_idx_t insn_vd_i,
  input  vreg_idx_t insn_vs1_i,
  input  vreg_idx_t insn_vs2_i,
  // Load port
  input  logic      wr_valid_i,
  input  vreg_idx_t wr_vreg_i,
  input  elem_idx_t wr_elem_i,
  input  elem_t     wr_data_i,
  // Store port
  input  logic      rd_req_i,
  input  vreg_idx_t rd_vreg_i,
  input  elem_idx_t rd_elem_i,
  output elem_t     rd_data_o,
  output logic      rd_valid_o,
  // Status
  output logic      busy_o,
  output logic      done_o
);

  ////////////////////////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////////////////////////

  // Operand fetch
  vreg_idx_t opa_vreg, opb_vreg;
  elem_idx_t op_elem;
  elem_t     opa, opb;

  // Unit issue
  logic      alu_issue, mul_issue;
  lane_op_e  issue_op;
  vreg_idx_t issue_vd;
  elem_idx_t issue_elem;

  // Result streams
  logic      alu_res_valid, mul_res_valid;
  vreg_idx_t alu_res_vd, mul_res_vd;
  elem_idx_t alu_res_elem, mul_res_elem;
  elem_t     alu_res_data, mul_res_data;

  // Register-file write from writeback
  logic      wb_valid;
  vreg_idx_t wb_vreg;
  elem_idx_t wb_elem;
  elem_t     wb_data;

  lane_sequencer u_sequencer (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .insn_valid_i(insn_valid_i),
    .insn_op_i   (insn_op_i   ),
    .insn_vd_i   (insn_vd_i   ),
    .insn_vs1_i  (insn_vs1_i  ),
    .insn_vs2_i  (insn_vs2_i  ),
    .done_i      (done_o      ),
    .busy_o      (busy_o      ),
    .opa_vreg_o  (opa_vreg    ),
    .opb_vreg_o  (opb_vreg    ),
    .op_elem_o   (op_elem     ),
    .alu_issue_o (alu_issue   ),
    .mul_issue_o (mul_issue   ),
    .issue_op_o  (issue_op    ),
    .issue_vd_o  (issue_vd    ),
    .issue_elem_o(issue_elem  )
  );

  vector_regfile u_vrf (
    .clk_i     (clk_i     ),
    .rst_ni    (rst_ni    ),
    .opa_vreg_i(opa_vreg  ),
    .opb_vreg_i(opb_vreg  ),
    .op_elem_i (op_elem   ),
    .opa_o     (opa       ),
    .opb_o     (opb       ),
    .wb_valid_i(wb_valid  ),
    .wb_vreg_i (wb_vreg   ),
    .wb_elem_i (wb_elem   ),
    .wb_data_i (wb_data   ),
    .wr_valid_i(wr_valid_i),
    .wr_vreg_i (wr_vreg_i ),
    .wr_elem_i (wr_elem_i ),
    .wr_data_i (wr_data_i ),
    .rd_req_i  (rd_req_i  ),
    .rd_vreg_i (rd_vreg_i ),
    .rd_elem_i (rd_elem_i ),
    .rd_data_o (rd_data_o ),
    .rd_valid_o(rd_valid_o)
  );

  lane_alu u_alu (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .issue_i    (alu_issue    ),
    .op_i       (issue_op     ),
    .vd_i       (issue_vd     ),
    .elem_i     (issue_elem   ),
    .opa_i      (opa          ),
    .opb_i      (opb          ),
    .res_valid_o(alu_res_valid),
    .res_vd_o   (alu_res_vd   ),
    .res_elem_o (alu_res_elem ),
    .res_data_o (alu_res_data )
  );

  lane_multiplier u_mul (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .issue_i    (mul_issue    ),
    .vd_i       (issue_vd     ),
    .elem_i     (issue_elem   ),
    .opa_i      (opa          ),
    .opb_i      (opb          ),
    .res_valid_o(mul_res_valid),
    .res_vd_o   (mul_res_vd   ),
    .res_elem_o (mul_res_elem ),
    .res_data_o (mul_res_data )
  );

  result_writeback u_wb (
    .clk_i          (clk_i        ),
    .rst_ni         (rst_ni       ),
    .alu_res_valid_i(alu_res_valid),
    .alu_res_vd_i   (alu_res_vd   ),
    .alu_res_elem_i (alu_res_elem ),
    .alu_res_data_i (alu_res_data ),
    .mul_res_valid_i(mul_res_valid),
    .mul_res_vd_i   (mul_res_vd   ),
    .mul_res_elem_i (mul_res_elem ),
    .mul_res_data_i (mul_res_data ),
    .wb_valid_o     (wb_valid     ),
    .wb_vreg_o      (wb_vreg      ),
    .wb_elem_o      (wb_elem      ),
    .wb_data_o      (wb_data      ),
    .done_o         (done_o       )
  );

endmodule : lane_top

/* sim/tb_lane.sv */
`timescale 1ns/10ps

module tb_lane import lane_pkg::*; ();

  localparam int NumTests   = 10;
  localparam int CycleLimit = NumTests * 20 + 200;

  // Opcode, vd, vs1, vs2, cycles from accept to done_o
  localparam int Stimulus [NumTests][5] = '{
    '{OP_VADD, 2, 0, 1, 7},
    '{OP_VSUB, 3, 1, 4, 7},
    '{OP_VAND, 5, 2, 6, 7},
    '{OP_VXOR, 6, 7, 3, 7},
    '{OP_VMUL, 4, 0, 5, 8},
    '{OP_VADD, 1, 1, 2, 7},
    '{OP_VMUL, 7, 7, 6, 8},
    '{OP_VSUB, 0, 0, 0, 7},
    '{OP_VXOR, 2, 2, 5, 7},
    '{OP_VMUL, 3, 3, 3, 8}
  };

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      insn_valid_i;
  lane_op_e  insn_op_i;
  vreg_idx_t insn_vd_i, insn_vs1_i, insn_vs2_i;
  logic      wr_valid_i;
  vreg_idx_t wr_vreg_i;
  elem_idx_t wr_elem_i;
  elem_t     wr_data_i;
  logic      rd_req_i;
  vreg_idx_t rd_vreg_i;
  elem_idx_t rd_elem_i;
  elem_t     rd_data_o;
  logic      rd_valid_o, busy_o, done_o;

  // Reference copy of the register file
  elem_t  model_mem [NrVRegs][VecElems];
  integer seed;
  int     errors;
  int     checks;
  int     cycle_cnt = 0;

  always #4 clk_i = ~clk_i;

  lane_top u_dut (.*);

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Run did not finish within %0d cycles", CycleLimit);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference rules and port tasks
  ////////////////////////////////////////////////////////////

  function automatic elem_t expect_elem(input lane_op_e op, input elem_t a, input elem_t b);
    logic [31:0] prod;
    prod = {16'h0000, a} * {16'h0000, b};
    case (op)
      OP_VADD: return a + b;
      OP_VSUB: return a - b;
      OP_VAND: return a & b;
      OP_VXOR: return a ^ b;
      default: return prod[15:0];
    endcase
  endfunction

  task automatic load_elem(input int v, input int e, input elem_t data);
    @(posedge clk_i);
    wr_valid_i <= 1'b1;
    wr_vreg_i  <= vreg_idx_t'(v);
    wr_elem_i  <= elem_idx_t'(e);
    wr_data_i  <= data;
    model_mem[v][e] = data;
  endtask

  // Store port read with data due one cycle after the request
  task automatic read_check(input int v, input int e);
    @(posedge clk_i);
    rd_req_i  <= 1'b1;
    rd_vreg_i <= vreg_idx_t'(v);
    rd_elem_i <= elem_idx_t'(e);
    @(negedge clk_i);
    checks++;
    if (rd_valid_o) begin
      errors++;
      $display("rd_valid_o was high before the read of v%0d[%0d] was sampled", v, e);
    end
    @(posedge clk_i);
    rd_req_i <= 1'b0;
    @(negedge clk_i);
    checks++;
    if (!rd_valid_o) begin
      errors++;
      $display("rd_valid_o did not follow the read of v%0d[%0d] by one cycle", v, e);
    end
    checks++;
    if (rd_data_o !== model_mem[v][e]) begin
      errors++;
      $display("ERR rd_data_o v%0d[%0d] exp %h got %h", v, e, model_mem[v][e], rd_data_o);
    end
  endtask

  task automatic run_insn(input int idx);
    lane_op_e op;
    int       vd, vs1, vs2, n, e;
    logic     seen;
    elem_t    res [VecElems];
    op   = lane_op_e'(Stimulus[idx][0]);
    vd   = Stimulus[idx][1];
    vs1  = Stimulus[idx][2];
    vs2  = Stimulus[idx][3];
    n    = 0;
    seen = 1'b0;
    for (e = 0; e < VecElems; e++) begin
      res[e] = expect_elem(op, model_mem[vs1][e], model_mem[vs2][e]);
    end
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    insn_op_i    <= op;
    insn_vd_i    <= vreg_idx_t'(vd);
    insn_vs1_i   <= vreg_idx_t'(vs1);
    insn_vs2_i   <= vreg_idx_t'(vs2);
    @(posedge clk_i);
    insn_valid_i <= 1'b0;
    while (!seen && n < 20) begin
      @(negedge clk_i);
      n++;
      checks++;
      if (!busy_o) begin
        errors++;
        $display("ERR busy_o insn %0d cycle %0d exp 1 got %h", idx, n, busy_o);
      end
      seen = done_o;
      @(posedge clk_i);
      // Stray strobe while busy would clear its vd if accepted
      if (n == 2) begin
        insn_valid_i <= 1'b1;
        insn_op_i    <= OP_VXOR;
        insn_vd_i    <= vreg_idx_t'(vd ^ 4);
        insn_vs1_i   <= vreg_idx_t'(vd ^ 4);
        insn_vs2_i   <= vreg_idx_t'(vd ^ 4);
      end else begin
        insn_valid_i <= 1'b0;
      end
    end
    checks++;
    if (!seen) begin
      errors++;
      $display("done_o never arrived for instruction %0d", idx);
    end else if (n != Stimulus[idx][4]) begin
      errors++;
      $display("done_o came %0d cycles after instruction %0d, expected %0d",
               n, idx, Stimulus[idx][4]);
    end
    @(negedge clk_i);
    checks++;
    if (done_o !== 1'b0) begin
      errors++;
      $display("ERR done_o after insn %0d exp 0 got %h", idx, done_o);
    end
    checks++;
    if (busy_o !== 1'b0) begin
      errors++;
      $display("ERR busy_o after insn %0d exp 0 got %h", idx, busy_o);
    end
    for (e = 0; e < VecElems; e++) begin
      model_mem[vd][e] = res[e];
    end
    for (e = 0; e < VecElems; e++) begin
      read_check(vd, e);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          v;
    int          e;
    logic [31:0] rnd;
    seed         = 57162;
    errors       = 0;
    checks       = 0;
    rst_ni       = 1'b0;
    insn_valid_i = 1'b0;
    insn_op_i    = OP_VADD;
    insn_vd_i    = '0;
    insn_vs1_i   = '0;
    insn_vs2_i   = '0;
    wr_valid_i   = 1'b0;
    wr_vreg_i    = '0;
    wr_elem_i    = '0;
    wr_data_i    = '0;
    rd_req_i     = 1'b0;
    rd_vreg_i    = '0;
    rd_elem_i    = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    checks++;
    if (busy_o !== 1'b0) begin
      errors++;
      $display("ERR busy_o after reset exp 0 got %h", busy_o);
    end
    checks++;
    if (done_o !== 1'b0) begin
      errors++;
      $display("ERR done_o after reset exp 0 got %h", done_o);
    end
    checks++;
    if (rd_valid_o !== 1'b0) begin
      errors++;
      $display("ERR rd_valid_o after reset exp 0 got %h", rd_valid_o);
    end
    // Fill every element with random data, then read it all back
    for (v = 0; v < NrVRegs; v++) begin
      for (e = 0; e < VecElems; e++) begin
        rnd = $random(seed);
        load_elem(v, e, rnd[15:0]);
      end
    end
    @(posedge clk_i);
    wr_valid_i <= 1'b0;
    for (v = 0; v < NrVRegs; v++) begin
      for (e = 0; e < VecElems; e++) begin
        read_check(v, e);
      end
    end
    for (int i = 0; i < NumTests; i++) begin
      run_insn(i);
    end
    // Registers untouched by the table, and stray targets, must hold their values
    for (v = 0; v < NrVRegs; v++) begin
      for (e = 0; e < VecElems; e++) begin
        read_check(v, e);
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_lane

/* sources.f */
common/lane_pkg.sv
vfu/lane_alu.sv
vfu/lane_multiplier.sv
vrf/vector_regfile.sv
vrf/result_writeback.sv
source/lane_sequencer.sv
source/lane_top.sv
sim/tb_lane.sv

/* Makefile */
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_lane: sources.f $(SRCS)
	verilator --binary --timescale 1ns/10ps --top-module tb_lane -f sources.f -o Vtb_lane

run: obj_dir/Vtb_lane
	@out="$$(./obj_dir/Vtb_lane)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
